// ==== modsq_config.svh ====
// configuration of the modular squaring engine (modulus, limb sizes, column widths)
`ifndef MODSQ_CONFIG_SVH
`define MODSQ_CONFIG_SVH

// odd modulus N
`define MODSQ_MODULUS       32'hFFFFFFFB

// limb geometry, a limb is one word plus a spare carry bit
`define MODSQ_WORD_LEN      8
`define MODSQ_BIT_LEN       9
`define MODSQ_NUM_WORDS     4
`define MODSQ_NUM_LIMBS     5

// square grid, columns 4 to 9 are folded back through the ROMs
`define MODSQ_NUM_COLS      10
`define MODSQ_NUM_UPPER     6

// column widths in the squarer and the accumulator trees
`define MODSQ_GRID_BIT_LEN  14
`define MODSQ_ACC_BIT_LEN   14

`endif

// ==== modsq_pkg.sv ====
// shared limb, operand and column types plus the fold ROM content function
`default_nettype none
`include "modsq_config.svh"

package modsq_pkg;

   typedef logic [`MODSQ_BIT_LEN-1:0] limb_t;        // word plus carry bit

   typedef struct packed {
      limb_t [`MODSQ_NUM_LIMBS-1:0] limb;             // limb 0 least significant
   } operand_t;

   typedef logic [`MODSQ_GRID_BIT_LEN-1:0] grid_col_t;
   typedef logic [`MODSQ_ACC_BIT_LEN-1:0]  acc_col_t;

   // partially reduced grid columns, each back to limb width
   typedef struct packed {
      limb_t [`MODSQ_NUM_COLS-1:0] col;
   } column_set_t;

   typedef struct packed {
      logic [`MODSQ_NUM_WORDS-1:0][`MODSQ_WORD_LEN-1:0] word;
   } rom_word_t;

   // addr * 2^(8*column) mod N for upper column (upper_idx + NUM_WORDS)
   function automatic rom_word_t fold_entry(input int unsigned upper_idx, input limb_t addr);
      logic [63:0] modulus;
      logic [63:0] value;
      int unsigned shift;
      modulus = 64'(`MODSQ_MODULUS);
      value   = 64'(addr) % modulus;
      shift   = `MODSQ_WORD_LEN * (upper_idx + `MODSQ_NUM_WORDS);
      for (int unsigned i = 0; i < shift; i++) begin
         value = value << 1;                        // double, then bring back below N
         if (value >= modulus) begin
            value = value - modulus;
         end
      end
      return rom_word_t'(value[`MODSQ_WORD_LEN*`MODSQ_NUM_WORDS-1:0]);
   endfunction

endpackage

`default_nettype wire

// ==== compressor_tree.sv ====
// 3:2 carry-save tree, reduces any number of terms to one carry and one sum
`timescale 1ns/10ps
`default_nettype none

module compressor_tree #(
   parameter type term_t    = logic [15:0],
   parameter int  NUM_TERMS = 3
) (
   input  term_t [NUM_TERMS-1:0] terms,
   output term_t                 carry,
   output term_t                 sum
);

   always_comb begin
      term_t row [NUM_TERMS+2];   // two spare rows stay zero
      term_t a;
      term_t b;
      term_t c;
      int    count;
      int    out_cnt;
      for (int i = 0; i < NUM_TERMS; i++) begin
         row[i] = terms[i];
      end
      row[NUM_TERMS]   = '0;
      row[NUM_TERMS+1] = '0;
      count = NUM_TERMS;

      // one full-adder layer per pass, three rows in and two rows out
      for (int layer = 0; layer < NUM_TERMS; layer++) begin
         if (count > 2) begin
            out_cnt = 0;
            for (int g = 0; g < NUM_TERMS; g += 3) begin
               if (g + 2 < count) begin
                  a = row[g];
                  b = row[g+1];
                  c = row[g+2];
                  row[out_cnt]   = a ^ b ^ c;
                  row[out_cnt+1] = term_t'(((a & b) | (a & c) | (b & c)) << 1);
                  out_cnt += 2;
               end
               else begin
                  for (int r = 0; r < 2; r++) begin   // leftovers ride to next layer
                     if (g + r < count) begin
                        row[out_cnt] = row[g+r];
                        out_cnt++;
                     end
                  end
               end
            end
            count = out_cnt;
         end
      end

      sum   = row[0];
      carry = row[1];   // zero spare when only one term came in
   end

endmodule

`default_nettype wire

// ==== iteration_control.sv ====
// phase sequencer for the squaring loop, start capture, operand select and valid
`timescale 1ns/10ps
`default_nettype none

module iteration_control (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 start,
   input  modsq_pkg::operand_t  sq_in,
   input  modsq_pkg::operand_t  sq_out,
   output modsq_pkg::operand_t  operand,
   output logic                 square_phase,
   output logic                 reduce_phase,
   output logic                 valid
);

   import modsq_pkg::*;

   localparam int IDLE   = 0;
   localparam int SQUARE = 1;
   localparam int REDUCE = 2;

   logic [2:0] phase;        // one-hot
   logic [2:0] phase_next;
   logic       pending;      // captured input waits for its square phase
   operand_t   sq_in_reg;

   always_comb begin
      phase_next = '0;
      case (1'b1)
         phase[SQUARE]: phase_next[REDUCE] = 1'b1;
         phase[REDUCE]: phase_next[SQUARE] = 1'b1;   // loop back, square again
         default: begin
            if (start) begin
               phase_next[SQUARE] = 1'b1;
            end
            else begin
               phase_next[IDLE] = 1'b1;
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         phase   <= 3'(1 << IDLE);
         valid   <= 1'b0;
         pending <= 1'b0;
      end
      else begin
         phase   <= phase_next;
         valid   <= phase[REDUCE];                       // result lands at end of reduce
         pending <= start | (pending & ~phase[SQUARE]);  // a new start beats the clear
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         sq_in_reg <= sq_in;
      end
   end

   assign operand      = pending ? sq_in_reg : sq_out;
   assign square_phase = phase[SQUARE];
   assign reduce_phase = phase[REDUCE];

endmodule

`default_nettype wire

// ==== square_grid.sv ====
// squarer that sums the doubled triangle of limb products per column and partially reduces it
`timescale 1ns/10ps
`default_nettype none
`include "modsq_config.svh"

module square_grid (
   input  logic                                         clk,
   input  modsq_pkg::operand_t                          operand,
   input  logic                                         square_phase,
   output modsq_pkg::column_set_t                       columns,
   output modsq_pkg::limb_t [`MODSQ_NUM_WORDS-1:0]      low_cols
);

   import modsq_pkg::*;

   localparam int WORD   = `MODSQ_WORD_LEN;
   localparam int BIT    = `MODSQ_BIT_LEN;
   localparam int GRID_W = `MODSQ_GRID_BIT_LEN;
   localparam int PROD_W = 2 * BIT;
   localparam int LAST   = `MODSQ_NUM_COLS - 1;

   grid_col_t [`MODSQ_NUM_COLS-1:0] grid [`MODSQ_NUM_COLS];   // grid[column][row]
   grid_col_t                       col_c [1:LAST-1];          // tree outputs, inner columns
   grid_col_t                       col_s [1:LAST-1];
   logic [GRID_W:0]                 col_sum [`MODSQ_NUM_COLS];

   // products on and above the diagonal split at the word boundary
   always_comb begin
      logic [PROD_W-1:0] prod;
      for (int k = 0; k < `MODSQ_NUM_COLS; k++) begin
         grid[k] = '0;
      end
      for (int i = 0; i < `MODSQ_NUM_LIMBS; i++) begin
         for (int j = i; j < `MODSQ_NUM_LIMBS; j++) begin
            prod = PROD_W'(operand.limb[i]) * PROD_W'(operand.limb[j]);
            if (i == j) begin
               grid[i+j][2*i]     = grid_col_t'(prod[WORD-1:0]);
               grid[i+j+1][2*i+1] = grid_col_t'(prod[PROD_W-1:WORD]);
            end
            else begin
               // off-diagonal terms appear twice so they move left by one bit
               grid[i+j][2*i]     = grid_col_t'({prod[WORD-2:0], 1'b0});
               grid[i+j+1][2*i+1] = grid_col_t'(prod[PROD_W-1:WORD-1]);
            end
         end
      end
   end

   for (genvar k = 1; k < LAST; k++) begin : g_col
      localparam int ROW_LO = (k < `MODSQ_NUM_LIMBS) ? 0 : 2 * k - (2 * `MODSQ_NUM_LIMBS - 1);
      localparam int ROW_HI = k;   // rows outside lo..hi are always zero

      compressor_tree #(
         .term_t    (grid_col_t),
         .NUM_TERMS (ROW_HI - ROW_LO + 1)
      ) u_tree (
         .terms (grid[k][ROW_HI:ROW_LO]),
         .carry (col_c[k]),
         .sum   (col_s[k])
      );
   end

   // carry-propagate each column and pass its high bits to the neighbour
   always_comb begin
      col_sum[0]    = {1'b0, grid[0][0]};          // first and last columns hold a single term
      col_sum[LAST] = {1'b0, grid[LAST][LAST]};
      for (int k = 1; k < LAST; k++) begin
         col_sum[k] = {1'b0, col_c[k]} + {1'b0, col_s[k]};
      end
      columns.col[0] = limb_t'(col_sum[0][WORD-1:0]);
      for (int k = 1; k < LAST; k++) begin
         columns.col[k] = limb_t'(col_sum[k][WORD-1:0]) + limb_t'(col_sum[k-1][GRID_W:WORD]);
      end
      columns.col[LAST] = col_sum[LAST][BIT-1:0] + limb_t'(col_sum[LAST-1][GRID_W:WORD]);
   end

   always_ff @(posedge clk) begin
      if (square_phase) begin
         low_cols <= columns.col[`MODSQ_NUM_WORDS-1:0];   // low columns skip the ROMs
      end
   end

endmodule

`default_nettype wire

// ==== reduction_rom.sv ====
// fold ROMs, map each upper column value to its residue mod N
`timescale 1ns/10ps
`default_nettype none
`include "modsq_config.svh"

module reduction_rom (
   input  logic                                          clk,
   input  modsq_pkg::column_set_t                        columns,
   input  logic                                          square_phase,
   output modsq_pkg::rom_word_t [`MODSQ_NUM_UPPER-1:0]   fold_words
);

   import modsq_pkg::*;

   localparam int ROM_DEPTH = 2 ** `MODSQ_BIT_LEN;   // full 9-bit column address

   rom_word_t rom [`MODSQ_NUM_UPPER][ROM_DEPTH];

   // contents follow directly from the modulus
   initial begin
      for (int u = 0; u < `MODSQ_NUM_UPPER; u++) begin
         for (int a = 0; a < ROM_DEPTH; a++) begin
            rom[u][a] = fold_entry(u, limb_t'(a));
         end
      end
   end

   // registered read, one cycle from column value to fold word
   always_ff @(posedge clk) begin
      if (square_phase) begin
         for (int u = 0; u < `MODSQ_NUM_UPPER; u++) begin
            fold_words[u] <= rom[u][columns.col[u + `MODSQ_NUM_WORDS]];
         end
      end
   end

endmodule

`default_nettype wire

// ==== reduction_accumulate.sv ====
// sums fold words and low columns into the next partially reduced operand
`timescale 1ns/10ps
`default_nettype none
`include "modsq_config.svh"

module reduction_accumulate (
   input  logic                                          clk,
   input  modsq_pkg::limb_t [`MODSQ_NUM_WORDS-1:0]       low_cols,
   input  modsq_pkg::rom_word_t [`MODSQ_NUM_UPPER-1:0]   fold_words,
   input  logic                                          reduce_phase,
   output modsq_pkg::operand_t                           sq_out
);

   import modsq_pkg::*;

   localparam int WORD  = `MODSQ_WORD_LEN;
   localparam int ACC_W = `MODSQ_ACC_BIT_LEN;
   localparam int TOP   = `MODSQ_NUM_LIMBS - 1;

   acc_col_t [`MODSQ_NUM_UPPER:0] stack [`MODSQ_NUM_WORDS];   // six fold words + low column
   acc_col_t                      acc_c [`MODSQ_NUM_WORDS];
   acc_col_t                      acc_s [`MODSQ_NUM_WORDS];
   logic [ACC_W:0]                acc_sum [`MODSQ_NUM_WORDS];
   operand_t                      next_sq;

   always_comb begin
      for (int l = 0; l < `MODSQ_NUM_WORDS; l++) begin
         for (int u = 0; u < `MODSQ_NUM_UPPER; u++) begin
            stack[l][u] = acc_col_t'(fold_words[u].word[l]);
         end
         stack[l][`MODSQ_NUM_UPPER] = acc_col_t'(low_cols[l]);
      end
   end

   for (genvar l = 0; l < `MODSQ_NUM_WORDS; l++) begin : g_limb
      compressor_tree #(
         .term_t    (acc_col_t),
         .NUM_TERMS (`MODSQ_NUM_UPPER + 1)
      ) u_tree (
         .terms (stack[l]),
         .carry (acc_c[l]),
         .sum   (acc_s[l])
      );
   end

   // carry-propagate per limb while the high bits move up one limb
   always_comb begin
      for (int l = 0; l < `MODSQ_NUM_WORDS; l++) begin
         acc_sum[l] = {1'b0, acc_c[l]} + {1'b0, acc_s[l]};
      end
      next_sq.limb[0] = limb_t'(acc_sum[0][WORD-1:0]);
      for (int l = 1; l < TOP; l++) begin
         next_sq.limb[l] = limb_t'(acc_sum[l][WORD-1:0]) + limb_t'(acc_sum[l-1][ACC_W:WORD]);
      end
      next_sq.limb[TOP] = limb_t'(acc_sum[TOP-1][ACC_W:WORD]);   // redundant top limb only collects carries
   end

   always_ff @(posedge clk) begin
      if (reduce_phase) begin
         sq_out <= next_sq;
      end
   end

endmodule

`default_nettype wire

// ==== modular_square.sv ====
// modular squaring engine top, closes the square, fold and accumulate loop
`timescale 1ns/10ps
`default_nettype none
`include "modsq_config.svh"

module modular_square (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 start,
   input  modsq_pkg::operand_t  sq_in,
   output modsq_pkg::operand_t  sq_out,
   output logic                 valid
);

   import modsq_pkg::*;

   operand_t                              operand;
   logic                                  square_phase;
   logic                                  reduce_phase;
   column_set_t                           columns;
   limb_t [`MODSQ_NUM_WORDS-1:0]          low_cols;
   rom_word_t [`MODSQ_NUM_UPPER-1:0]      fold_words;

   iteration_control u_control (
      .clk          (clk),
      .reset        (reset),
      .start        (start),
      .sq_in        (sq_in),
      .sq_out       (sq_out),      // loopback
      .operand      (operand),
      .square_phase (square_phase),
      .reduce_phase (reduce_phase),
      .valid        (valid)
   );

   square_grid u_grid (
      .clk          (clk),
      .operand      (operand),
      .square_phase (square_phase),
      .columns      (columns),
      .low_cols     (low_cols)
   );

   reduction_rom u_rom (
      .clk          (clk),
      .columns      (columns),
      .square_phase (square_phase),
      .fold_words   (fold_words)
   );

   reduction_accumulate u_acc (
      .clk          (clk),
      .low_cols     (low_cols),
      .fold_words   (fold_words),
      .reduce_phase (reduce_phase),
      .sq_out       (sq_out)
   );

endmodule

`default_nettype wire

// ==== tb_modular_square.sv ====
// testbench for the modular squaring engine, pattern file plus per-step residue checks
`timescale 1ns/10ps
`default_nettype none
`include "modsq_config.svh"

module tb_modular_square;

   import modsq_pkg::*;

   localparam logic [63:0] MODULUS = 64'(`MODSQ_MODULUS);
   localparam int NUM_FILE     = 9;    // lines in the patterns file
   localparam int NUM_RAND     = 3;    // random start values, two more for the swap test
   localparam int RAND_STEPS   = 8;
   localparam int SWAP_STEPS   = 4;
   localparam int IDLE_CYCLES  = 4;
   localparam int SETUP_CYCLES = 20;   // reset, idle watch and start around each chain

   logic     clk;
   logic     reset;
   logic     start;
   operand_t sq_in;
   operand_t sq_out;
   logic     valid;

   logic [31:0] pat_mem [3*NUM_FILE];
   logic [31:0] rand_start [NUM_RAND+2];
   int          error_count;
   int          check_count;
   int          cycle_count;
   int          cycle_limit = 1000000;   // replaced once the patterns are known
   int          seed;

   modular_square dut_i (
      .clk    (clk),
      .reset  (reset),
      .start  (start),
      .sq_in  (sq_in),
      .sq_out (sq_out),
      .valid  (valid)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // word i goes to limb i with a clear carry bit, top limb stays zero
   function automatic operand_t to_limbs(input logic [31:0] value);
      operand_t op;
      op = '0;
      for (int i = 0; i < `MODSQ_NUM_WORDS; i++) begin
         op.limb[i] = limb_t'(value[`MODSQ_WORD_LEN*i +: `MODSQ_WORD_LEN]);
      end
      return op;
   endfunction

   function automatic logic [63:0] limbs_value(input operand_t op);
      logic [63:0] total;
      total = '0;
      for (int i = 0; i < `MODSQ_NUM_LIMBS; i++) begin
         total = total + (64'(op.limb[i]) << (`MODSQ_WORD_LEN * i));   // limb i weighs 2^(8i)
      end
      return total;
   endfunction

   function automatic logic [63:0] square_mod(input logic [63:0] x);
      return (x * x) % MODULUS;   // x below N, so the square fits 64 bits
   endfunction

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      check_count++;
      if (actual !== expected) begin
         $display("ERR at %0t: %s is %h, expected %h", $time, name, actual, expected);
         error_count++;
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #2;
      reset = 1'b1;
      start = 1'b0;
      repeat (5) @(posedge clk);
      #2;
      reset = 1'b0;
   endtask

   // no start yet, so no loopback may show up
   task automatic watch_idle();
      repeat (IDLE_CYCLES) begin
         @(posedge clk);
         #1;
         check_value("valid", 64'(valid), 64'd0);
      end
   endtask

   task automatic start_engine(input logic [31:0] value);
      @(posedge clk);
      #2;
      start = 1'b1;
      sq_in = to_limbs(value);
      @(posedge clk);
      #2;
      start = 1'b0;
   endtask

   // returns the number of rising edges until valid is seen
   task automatic next_valid(output int gap);
      gap = 0;
      do begin
         @(posedge clk);
         #1;
         gap++;
      end while (!valid);
   endtask

   task automatic run_chain(input logic [31:0] value, input int steps);
      int          gap;
      logic [63:0] expected;
      expected = 64'(value);
      start_engine(value);
      for (int s = 0; s < steps; s++) begin
         next_valid(gap);
         check_value("valid gap", 64'(gap), 64'd2);   // first one two edges after start
         expected = square_mod(expected);
         check_value("sq_out mod N", limbs_value(sq_out) % MODULUS, expected);
      end
   endtask

   // new start during a square phase, the old chain still gets one more result
   task automatic swap_operand(input logic [31:0] first, input logic [31:0] second);
      int          gap;
      logic [63:0] expected;
      start_engine(first);
      next_valid(gap);
      expected = square_mod(64'(first));
      check_value("sq_out mod N", limbs_value(sq_out) % MODULUS, expected);
      #1;
      start = 1'b1;
      sq_in = to_limbs(second);
      @(posedge clk);
      #2;
      start = 1'b0;
      next_valid(gap);
      check_value("valid gap", 64'(gap), 64'd1);
      expected = square_mod(expected);
      check_value("sq_out mod N", limbs_value(sq_out) % MODULUS, expected);
      expected = 64'(second);
      for (int s = 0; s < 2; s++) begin
         next_valid(gap);
         check_value("valid gap", 64'(gap), 64'd2);
         expected = square_mod(expected);
         check_value("sq_out mod N", limbs_value(sq_out) % MODULUS, expected);
      end
   endtask

   initial begin
      logic [31:0] raw;
      int          total;
      reset       = 1'b1;
      start       = 1'b0;
      sq_in       = '0;
      error_count = 0;
      check_count = 0;
      seed        = 32'h821c;
      $readmemh("modsq_patterns.hex", pat_mem);
      for (int r = 0; r < NUM_RAND + 2; r++) begin
         raw = $random(seed);
         if (64'(raw) >= MODULUS) begin
            raw = raw - `MODSQ_MODULUS;   // keep start values below N
         end
         rand_start[r] = raw;
      end

      total = 50;
      for (int p = 0; p < NUM_FILE; p++) begin
         total += int'(pat_mem[3*p+1]) * 2 + SETUP_CYCLES;
      end
      total += NUM_RAND * (RAND_STEPS * 2 + SETUP_CYCLES);
      total += SWAP_STEPS * 2 + SETUP_CYCLES;
      cycle_limit = total;

      apply_reset();
      for (int p = 0; p < NUM_FILE; p++) begin
         watch_idle();
         run_chain(pat_mem[3*p], int'(pat_mem[3*p+1]));
         check_value("final sq_out mod N", limbs_value(sq_out) % MODULUS,
                     64'(pat_mem[3*p+2]));
         apply_reset();
      end
      for (int r = 0; r < NUM_RAND; r++) begin
         watch_idle();
         run_chain(rand_start[r], RAND_STEPS);
         apply_reset();
      end
      watch_idle();
      swap_operand(rand_start[NUM_RAND], rand_start[NUM_RAND+1]);

      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("No errors");
      end
      else begin
         $display("Errors found");
      end
      $finish;
   end

   // hang guard, the limit follows from the pattern lengths
   initial begin
      cycle_count = 0;
      while (cycle_count < cycle_limit) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout after %0d cycles, valid never arrived", cycle_count);
      $display("checks %0d, errors %0d", check_count, error_count);
      $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== modsq_patterns.hex ====
// start value, squaring count, expected residue after that many squarings mod FFFFFFFB
// one pattern per line, all three fields in hex
00000000 00000003 00000000
00000001 00000004 00000001
00000002 00000009 86F27070
FFFFFFFA 00000003 00000001
00000003 00000004 0290D741
00010000 00000002 00000019
0000FFFF 00000001 FFFE0001
FFFFFFF9 00000002 00000010
80000000 00000001 40000005

// ==== modular_square.f ====
+incdir+.
modsq_pkg.sv
compressor_tree.sv
iteration_control.sv
square_grid.sv
reduction_rom.sv
reduction_accumulate.sv
modular_square.sv
tb_modular_square.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -f modular_square.f --top-module tb_modular_square \
   --Mdir obj_dir -o tb_modular_square
./obj_dir/tb_modular_square > sim.log 2>&1
cat sim.log

if grep -q "Errors found" sim.log; then
   echo "simulation FAILED"
   exit 1
fi
echo "simulation PASSED"
